// File: verilog.f
+incdir+.
alut_entry_pkg.sv
alut_ctrl_pkg.sv
alut_mem.sv
alut_age_checker.sv
alut_addr_checker.sv
alut_top.sv
alut_scoreboard.sv
tb_alut.sv

// File: run_sim.sh
#!/bin/sh
# builds the address lookup testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"
rm -rf obj_dir sim.log
verilator --binary --timing --timescale 1ns/1ps -f verilog.f \
   --top-module tb_alut -o sim_alut
./obj_dir/sim_alut > sim.log
cat sim.log
grep -q "SIMULATION PASSED" sim.log

// File: tb_alut.sv
// testbench for the address lookup subsystem
// drives check commands on the falling clock edge, keeps a reference
// copy of the table and passes the expected results to the scoreboard
`timescale 1ns/1ps
`include "alut_defines.svh"

module tb_alut;

   import alut_entry_pkg::*;
   import alut_ctrl_pkg::*;

   localparam logic [31:0] SEED       = 32'h93ea_6b82;
   localparam logic [31:0] MAX_AGE    = 32'd300;   // cycles an entry stays in date
   localparam int          WAIT_LIMIT = 40;        // cycles allowed for each wait
   localparam logic [47:0] OWN_MAC    = 48'h0200_5e10_0001;
   localparam logic [47:0] ADDR_A     = 48'h0011_2233_4455;   // hash 11
   localparam logic [47:0] ADDR_B     = 48'h0066_7788_99aa;   // hash aa
   localparam logic [47:0] ADDR_C     = 48'h00c0_ffee_1234;   // hash f7
   localparam logic [47:0] ADDR_U     = 48'h0a0b_0c0d_0e0f;   // never learned
   localparam logic [47:0] ADDR_X     = ADDR_A ^ 48'h0000_0101_0000;  // same hash as A

   logic                    pclk1 = 1'b0;
   logic                    n_p_reset1;
   alut_cmd_t               command;
   frame_info_t             frame;
   logic [`ALUT_ADDR_W-1:0] mac_addr;
   logic [`ALUT_TIME_W-1:0] curr_time;
   logic [`ALUT_TIME_W-1:0] max_age;
   logic                    clear_reused;
   dport_t                  d_port;
   logic                    add_check_active;
   logic                    reused;
   logic [`ALUT_ADDR_W-1:0] lst_inv_addr;
   logic [`ALUT_PORT_W-1:0] lst_inv_port;

   dport_t                  exp_d_port;     // model results for the scoreboard
   logic                    exp_reused;
   logic [`ALUT_ADDR_W-1:0] exp_inv_addr;
   logic [`ALUT_PORT_W-1:0] exp_inv_port;
   logic                    spot_req;
   int                      check_count;
   int                      error_count;
   logic                    timed_out;

   alut_entry_t             model_tbl [`ALUT_DEPTH];   // reference table
   logic [`ALUT_ADDR_W-1:0] pool [8];                  // random traffic addresses

   always #20 pclk1 = ~pclk1;   // 40 ns period

   alut_top u_alut_top
   (
      .pclk1 (pclk1), .n_p_reset1 (n_p_reset1), .command (command), .frame (frame),
      .mac_addr (mac_addr), .curr_time (curr_time), .max_age (max_age),
      .clear_reused (clear_reused), .d_port (d_port), .add_check_active (add_check_active),
      .reused (reused), .lst_inv_addr (lst_inv_addr), .lst_inv_port (lst_inv_port)
   );

   alut_scoreboard u_scoreboard
   (
      .pclk1 (pclk1), .n_p_reset1 (n_p_reset1), .d_port (d_port),
      .add_check_active (add_check_active), .reused (reused),
      .lst_inv_addr (lst_inv_addr), .lst_inv_port (lst_inv_port),
      .exp_d_port (exp_d_port), .exp_reused (exp_reused), .exp_inv_addr (exp_inv_addr),
      .exp_inv_port (exp_inv_port), .spot_req (spot_req),
      .check_count (check_count), .error_count (error_count)
   );

   // table index from all six address bytes
   function automatic logic [`ALUT_HASH_W-1:0] xor_fold(input logic [47:0] a);
      return a[47:40] ^ a[39:32] ^ a[31:24] ^ a[23:16] ^ a[15:8] ^ a[7:0];
   endfunction

   // one clock with curr_time counted on the falling edge
   task automatic step_cycle();
      @(negedge pclk1);
      curr_time = curr_time + 32'd1;
   endtask

   task automatic spot_check();
      step_cycle();
      spot_req = 1'b1;
      step_cycle();
      spot_req = 1'b0;
   endtask

   task automatic pulse_clear();
      step_cycle();
      clear_reused = 1'b1;
      step_cycle();
      clear_reused = 1'b0;
      exp_reused   = 1'b0;   // evicted address and port stay
   endtask

   // ----------------------------------------------------------------------
   // one check from prediction to learning in the model
   // ----------------------------------------------------------------------
   task automatic run_check(input logic [47:0] d_addr, input logic [47:0] s_addr,
                            input logic [1:0] s_port);
      alut_entry_t dst;
      alut_entry_t src;
      logic [31:0] t_age;
      logic [31:0] t_wr;
      logic [3:0]  src_bit;
      logic        in_date;
      int          n;
      if (timed_out)
         return;
      step_cycle();
      src_bit = 4'b0001 << s_port;
      t_age   = curr_time + 32'd5;   // age judged at the end of the 5th active cycle
      t_wr    = curr_time;
      if (d_addr == mac_addr)
         exp_d_port = '{own_mac: 1'b1, eth: 4'b0000};
      else
      begin
         dst     = model_tbl[xor_fold(d_addr)];
         in_date = (t_age - dst.last_time) < max_age;   // wraps like the counter
         if (dst.valid && in_date && dst.addr == d_addr)
            exp_d_port = '{own_mac: 1'b0, eth: (4'b0001 << dst.port) & ~src_bit};
         else
            exp_d_port = '{own_mac: 1'b0, eth: ~src_bit};   // flood
         src = model_tbl[xor_fold(s_addr)];
         if (src.valid && src.addr != s_addr)
         begin
            exp_reused   = 1'b1;
            exp_inv_addr = src.addr;
            exp_inv_port = src.port;
         end
      end
      frame   = '{d_addr: d_addr, s_addr: s_addr, s_port: s_port};
      command = `ALUT_CMD_CHECK;
      n = 0;
      while (!add_check_active && n < WAIT_LIMIT)
      begin
         step_cycle();
         command = '0;
         n++;
      end
      command = '0;
      if (!add_check_active)
      begin
         $display("timeout: the check did not start within %0d cycles", WAIT_LIMIT);
         timed_out = 1'b1;
         return;
      end
      n = 0;
      while (add_check_active && n < WAIT_LIMIT)
      begin
         t_wr = curr_time;   // taken by the DUT at the next rising edge
         step_cycle();
         n++;
      end
      if (add_check_active)
      begin
         $display("timeout: the check did not finish within %0d cycles", WAIT_LIMIT);
         timed_out = 1'b1;
         return;
      end
      if (d_addr != mac_addr)
         model_tbl[xor_fold(s_addr)] = '{valid: 1'b1, last_time: t_wr, port: s_port,
                                         addr: s_addr};
   endtask

   // ----------------------------------------------------------------------
   // test sequence
   // ----------------------------------------------------------------------
   initial
   begin
      int d_sel;
      n_p_reset1   = 1'b0;
      command      = '0;
      frame        = '0;
      mac_addr     = OWN_MAC;
      curr_time    = '0;
      max_age      = MAX_AGE;
      clear_reused = 1'b0;
      exp_d_port   = '{own_mac: 1'b0, eth: 4'b1111};
      exp_reused   = 1'b0;
      exp_inv_addr = '0;
      exp_inv_port = '0;
      spot_req     = 1'b0;
      timed_out    = 1'b0;
      void'($urandom(SEED));
      for (int i = 0; i < `ALUT_DEPTH; i++)
         model_tbl[i] = '0;
      repeat (3) step_cycle();
      n_p_reset1 = 1'b1;

      spot_check();                       // reset values
      run_check(ADDR_U, ADDR_A, 2'd1);    // unknown destination floods and A is learned
      run_check(OWN_MAC, ADDR_B, 2'd2);   // own mac so nothing is learned
      run_check(ADDR_B, ADDR_C, 2'd0);    // B still unknown
      run_check(ADDR_A, ADDR_C, 2'd3);    // forward to port 1
      run_check(ADDR_A, ADDR_A, 2'd1);    // back to its own port gives no output
      repeat (MAX_AGE + 10) step_cycle();
      run_check(ADDR_A, ADDR_B, 2'd2);    // A aged out
      run_check(ADDR_C, ADDR_X, 2'd2);    // X evicts A
      pulse_clear();
      spot_check();

      for (int i = 0; i < 4; i++)
      begin
         pool[i]     = {16'h0200, $urandom};
         pool[i + 4] = pool[i] ^ 48'h0000_0000_5a5a;   // collides with pool[i]
      end
      for (int k = 0; k < 200; k++)
      begin
         d_sel = int'($urandom % 9);
         run_check((d_sel == 8) ? OWN_MAC : pool[d_sel], pool[int'($urandom % 8)],
                   2'($urandom % 4));
         if ($urandom % 10 == 0)
            pulse_clear();
         repeat ($urandom % 12) step_cycle();
      end

      repeat (2) step_cycle();
      $display("checks %0d, errors %0d, timeouts %0d", check_count, error_count,
               timed_out);
      if (timed_out || error_count != 0 || check_count == 0)
         $display("SIMULATION FAILED");
      else
         $display("SIMULATION PASSED");
      $finish;
   end

endmodule

// File: alut_scoreboard.sv
// scoreboard for the lookup table testbench
// watches the DUT's top-level outputs and compares them with the
// expected values from the testbench, once when a check ends and once
// for every spot check that the testbench requests. keeps the counts
`timescale 1ns/1ps
`include "alut_defines.svh"

module alut_scoreboard
(
   input  logic                     pclk1,
   input  logic                     n_p_reset1,
   input  alut_ctrl_pkg::dport_t    d_port,            // DUT probes
   input  logic                     add_check_active,
   input  logic                     reused,
   input  logic [`ALUT_ADDR_W-1:0]  lst_inv_addr,
   input  logic [`ALUT_PORT_W-1:0]  lst_inv_port,
   input  alut_ctrl_pkg::dport_t    exp_d_port,        // from the model
   input  logic                     exp_reused,
   input  logic [`ALUT_ADDR_W-1:0]  exp_inv_addr,
   input  logic [`ALUT_PORT_W-1:0]  exp_inv_port,
   input  logic                     spot_req,          // compare now, no check running
   output int                       check_count,
   output int                       error_count
);

   int   checks = 0;
   int   errors = 0;
   logic active_q = 1'b0;   // add_check_active one cycle back

   assign check_count = checks;
   assign error_count = errors;

   // ----------------------------------------------------------------------
   // compare every output against the model
   // ----------------------------------------------------------------------
   task automatic compare_outputs(input logic idle_expected);
      int bad;
      bad = 0;
      checks++;
      if (d_port !== exp_d_port)
      begin
         $display("mismatch d_port in test %0d: got %h, expected %h", checks, d_port,
                  exp_d_port);
         bad++;
      end
      if (reused !== exp_reused)
      begin
         $display("mismatch reused in test %0d: got %h, expected %h", checks, reused,
                  exp_reused);
         bad++;
      end
      if (lst_inv_addr !== exp_inv_addr)
      begin
         $display("mismatch lst_inv_addr in test %0d: got %h, expected %h", checks,
                  lst_inv_addr, exp_inv_addr);
         bad++;
      end
      if (lst_inv_port !== exp_inv_port)
      begin
         $display("mismatch lst_inv_port in test %0d: got %h, expected %h", checks,
                  lst_inv_port, exp_inv_port);
         bad++;
      end
      if (idle_expected && add_check_active !== 1'b0)   // spot checks run between checks
      begin
         $display("mismatch add_check_active in test %0d: got %h, expected 0", checks,
                  add_check_active);
         bad++;
      end
      errors += bad;
      if (bad == 0)
         $display("test %0d passed, d_port %h reused %h", checks, d_port, reused);
      else
         $display("test %0d failed with %0d mismatches", checks, bad);
   endtask

   // ----------------------------------------------------------------------
   // end of check is the fall of add_check_active
   // ----------------------------------------------------------------------
   always @(negedge pclk1)
   begin
      #5;   // testbench drives on this edge, look once things settle
      if (!n_p_reset1)
         active_q = 1'b0;
      else
      begin
         if (active_q && !add_check_active)
            compare_outputs(1'b0);   // results final on the fall
         else if (spot_req)
            compare_outputs(1'b1);
         active_q = add_check_active;
      end
   end

endmodule

// File: alut_top.sv
// top of the address lookup subsystem
// ties the address checker to its age checker and the table and
// presents the switch-facing command, frame and result ports
`timescale 1ns/1ps
`include "alut_defines.svh"

module alut_top
(
   input  logic                         pclk1,
   input  logic                         n_p_reset1,
   input  alut_ctrl_pkg::alut_cmd_t     command,
   input  alut_entry_pkg::frame_info_t  frame,
   input  logic [`ALUT_ADDR_W-1:0]      mac_addr,
   input  logic [`ALUT_TIME_W-1:0]      curr_time,
   input  logic [`ALUT_TIME_W-1:0]      max_age,
   input  logic                         clear_reused,
   output alut_ctrl_pkg::dport_t        d_port,
   output logic                         add_check_active,
   output logic                         reused,
   output logic [`ALUT_ADDR_W-1:0]      lst_inv_addr,
   output logic [`ALUT_PORT_W-1:0]      lst_inv_port
);

   import alut_entry_pkg::*;

   // ----------------------------------------------------------------------
   // checker to table and age checker
   // ----------------------------------------------------------------------
   logic [`ALUT_HASH_W-1:0] mem_addr;
   logic                    mem_write;
   alut_entry_t             mem_write_data;
   alut_entry_t             mem_read_data;
   logic                    check_age;
   logic [`ALUT_TIME_W-1:0] last_accessed;
   logic                    age_confirmed;
   logic                    age_ok;

   alut_addr_checker u_addr_checker
   (
      .pclk1            (pclk1),
      .n_p_reset1       (n_p_reset1),
      .command          (command),
      .frame            (frame),
      .mac_addr         (mac_addr),
      .curr_time        (curr_time),
      .mem_read_data    (mem_read_data),
      .age_confirmed    (age_confirmed),
      .age_ok           (age_ok),
      .clear_reused     (clear_reused),
      .d_port           (d_port),
      .add_check_active (add_check_active),
      .mem_addr         (mem_addr),
      .mem_write        (mem_write),
      .mem_write_data   (mem_write_data),
      .check_age        (check_age),
      .last_accessed    (last_accessed),
      .reused           (reused),
      .lst_inv_addr     (lst_inv_addr),
      .lst_inv_port     (lst_inv_port)
   );

   alut_age_checker u_age_checker
   (
      .pclk1         (pclk1),
      .n_p_reset1    (n_p_reset1),
      .check_age     (check_age),
      .last_accessed (last_accessed),
      .curr_time     (curr_time),
      .max_age       (max_age),
      .age_confirmed (age_confirmed),
      .age_ok        (age_ok)
   );

   alut_mem u_mem
   (
      .pclk1          (pclk1),
      .n_p_reset1     (n_p_reset1),
      .mem_addr       (mem_addr),
      .mem_write      (mem_write),
      .mem_write_data (mem_write_data),
      .mem_read_data  (mem_read_data)
   );

endmodule

// File: alut_addr_checker.sv
// address checker for the lookup table
// on a check command it looks up the destination, returns the port
// vector, then learns the source address into the table. an overwrite
// of a different valid address raises the sticky reused flag
`timescale 1ns/1ps
`include "alut_defines.svh"

module alut_addr_checker
(
   input  logic                         pclk1,
   input  logic                         n_p_reset1,
   input  alut_ctrl_pkg::alut_cmd_t     command,
   input  alut_entry_pkg::frame_info_t  frame,
   input  logic [`ALUT_ADDR_W-1:0]      mac_addr,         // switch's own address
   input  logic [`ALUT_TIME_W-1:0]      curr_time,
   input  alut_entry_pkg::alut_entry_t  mem_read_data,    // combinational from table
   input  logic                         age_confirmed,
   input  logic                         age_ok,           // holds until next request
   input  logic                         clear_reused,
   output alut_ctrl_pkg::dport_t        d_port,
   output logic                         add_check_active,
   output logic [`ALUT_HASH_W-1:0]      mem_addr,
   output logic                         mem_write,
   output alut_entry_pkg::alut_entry_t  mem_write_data,
   output logic                         check_age,
   output logic [`ALUT_TIME_W-1:0]      last_accessed,
   output logic                         reused,
   output logic [`ALUT_ADDR_W-1:0]      lst_inv_addr,
   output logic [`ALUT_PORT_W-1:0]      lst_inv_port
);

   import alut_entry_pkg::*;
   import alut_ctrl_pkg::*;

   add_chk_state_t          state;
   add_chk_state_t          nxt_state;
   alut_entry_t             dest_entry;   // destination entry held from valid_chk
   logic [`ALUT_HASH_W-1:0] s_hash;
   logic [`ALUT_HASH_W-1:0] d_hash;
   logic                    own_mac_hit;
   logic                    dest_hit;     // valid, in date and same address
   logic                    evict;        // learning replaces another address
   logic [`ALUT_NPORTS-1:0] src_bit;      // one-hot of the source port
   logic [`ALUT_NPORTS-1:0] fwd_bit;      // one-hot of the stored port

   // xor of all address bytes
   function automatic logic [`ALUT_HASH_W-1:0] hash_addr(
      input logic [`ALUT_ADDR_W-1:0] addr);
      logic [`ALUT_HASH_W-1:0] h;
      h = '0;
      for (int i = 0; i < `ALUT_ADDR_W / `ALUT_HASH_W; i++)
         h = h ^ addr[i*`ALUT_HASH_W +: `ALUT_HASH_W];
      return h;
   endfunction

   // ----------------------------------------------------------------------
   // hashing and decode helpers
   // ----------------------------------------------------------------------
   assign s_hash      = hash_addr(frame.s_addr);
   assign d_hash      = hash_addr(frame.d_addr);
   assign own_mac_hit = (frame.d_addr == mac_addr);
   assign dest_hit    = age_ok & (dest_entry.addr == frame.d_addr);
   assign evict       = mem_read_data.valid & (mem_read_data.addr != frame.s_addr);

   always_comb
   begin
      src_bit = '0;
      fwd_bit = '0;
      src_bit[frame.s_port]     = 1'b1;
      fwd_bit[dest_entry.port]  = 1'b1;
   end

   // ----------------------------------------------------------------------
   // check FSM
   // ----------------------------------------------------------------------
   always_comb
   begin
      nxt_state = state;
      case (state)
         idle:         if (command == `ALUT_CMD_CHECK) nxt_state = mac_addr_chk;
         mac_addr_chk: nxt_state = own_mac_hit ? idle : read_dest;
         read_dest:    nxt_state = valid_chk;
         valid_chk:    nxt_state = mem_read_data.valid ? age_chk : read_src;
         age_chk:      if (age_confirmed) nxt_state = addr_chk;
         addr_chk:     nxt_state = read_src;
         read_src:     nxt_state = write_src;
         write_src:    nxt_state = idle;
         default:      nxt_state = idle;
      endcase
   end

   always_ff @(posedge pclk1 or negedge n_p_reset1)
   begin
      if (!n_p_reset1)
         state <= idle;
      else
         state <= nxt_state;
   end

   assign add_check_active = (state != idle);

   // ----------------------------------------------------------------------
   // table access
   // ----------------------------------------------------------------------
   // destination hash until the learning half of the check
   assign mem_addr  = ((state == read_src) || (state == write_src)) ? s_hash : d_hash;
   assign mem_write = (state == write_src);

   always_comb
   begin
      mem_write_data.valid     = 1'b1;           // learned entries are always valid
      mem_write_data.last_time = curr_time;
      mem_write_data.port      = frame.s_port;
      mem_write_data.addr      = frame.s_addr;
   end

   // keep destination entry, table is readdressed to the source later
   always_ff @(posedge pclk1)
   begin
      if (state == valid_chk)
         dest_entry <= mem_read_data;
   end

   // ----------------------------------------------------------------------
   // age request
   // ----------------------------------------------------------------------
   // one pulse in the second age_chk cycle, answer comes in the third
   always_ff @(posedge pclk1 or negedge n_p_reset1)
   begin
      if (!n_p_reset1)
         check_age <= 1'b0;
      else
         check_age <= (state == age_chk) & ~check_age & ~age_confirmed;
   end

   assign last_accessed = dest_entry.last_time;

   // ----------------------------------------------------------------------
   // destination port
   // ----------------------------------------------------------------------
   always_ff @(posedge pclk1 or negedge n_p_reset1)
   begin
      if (!n_p_reset1)
         d_port <= '{own_mac: 1'b0, eth: '1};      // broadcast out of reset
      else
      begin
         case (state)
            mac_addr_chk:
               if (own_mac_hit)
                  d_port <= '{own_mac: 1'b1, eth: '0};
            valid_chk:
               if (!mem_read_data.valid)
                  d_port <= '{own_mac: 1'b0, eth: ~src_bit};   // unknown, flood
            addr_chk:
               if (dest_hit)
                  d_port <= '{own_mac: 1'b0, eth: fwd_bit & ~src_bit};
               else
                  d_port <= '{own_mac: 1'b0, eth: ~src_bit};   // stale or other addr
            default: ;
         endcase
      end
   end

   // ----------------------------------------------------------------------
   // reuse reporting
   // ----------------------------------------------------------------------
   always_ff @(posedge pclk1 or negedge n_p_reset1)
   begin
      if (!n_p_reset1)
      begin
         reused       <= 1'b0;
         lst_inv_addr <= '0;
         lst_inv_port <= '0;
      end
      else if ((state == read_src) && evict)
      begin
         reused       <= 1'b1;                    // wins over a clear in same cycle
         lst_inv_addr <= mem_read_data.addr;
         lst_inv_port <= mem_read_data.port;
      end
      else if (clear_reused)
         reused <= 1'b0;                          // evicted fields stay readable
   end

endmodule

// File: alut_age_checker.sv
// age checker for learned table entries
// pulse check_age with the stored time stamp; one cycle later
// age_confirmed pulses and age_ok says whether the entry is in date
`timescale 1ns/1ps
`include "alut_defines.svh"

module alut_age_checker
(
   input  logic                    pclk1,
   input  logic                    n_p_reset1,
   input  logic                    check_age,      // single-cycle request
   input  logic [`ALUT_TIME_W-1:0] last_accessed,  // time stamp of the entry
   input  logic [`ALUT_TIME_W-1:0] curr_time,
   input  logic [`ALUT_TIME_W-1:0] max_age,
   output logic                    age_confirmed,  // single-cycle answer
   output logic                    age_ok
);

   logic [`ALUT_TIME_W-1:0] age;  // time since last write

   // modular difference, survives a wrap of curr_time
   assign age = curr_time - last_accessed;

   always_ff @(posedge pclk1 or negedge n_p_reset1)
   begin
      if (!n_p_reset1)
      begin
         age_confirmed <= 1'b0;
         age_ok        <= 1'b0;
      end
      else
      begin
         age_confirmed <= check_age;
         if (check_age)
            age_ok <= (age < max_age);  // level held until the next request
      end
   end

endmodule

// File: alut_mem.sv
// lookup table storage, `ALUT_DEPTH entries
// read is combinational on mem_addr, write happens on the clock edge
// when mem_write is high. reset only invalidates the entries
`timescale 1ns/1ps
`include "alut_defines.svh"

module alut_mem
(
   input  logic                         pclk1,
   input  logic                         n_p_reset1,
   input  logic [`ALUT_HASH_W-1:0]      mem_addr,
   input  logic                         mem_write,
   input  alut_entry_pkg::alut_entry_t  mem_write_data,
   output alut_entry_pkg::alut_entry_t  mem_read_data
);

   import alut_entry_pkg::*;

   alut_entry_t             entry_q [`ALUT_DEPTH];  // payload, no reset
   logic [`ALUT_DEPTH-1:0]  valid_q;                // per-entry valid flags

   always_ff @(posedge pclk1 or negedge n_p_reset1)
   begin
      if (!n_p_reset1)
         valid_q <= '0;
      else if (mem_write)
         valid_q[mem_addr] <= mem_write_data.valid;
   end

   always_ff @(posedge pclk1)
   begin
      if (mem_write)
         entry_q[mem_addr] <= mem_write_data;
   end

   always_comb
   begin
      mem_read_data       = entry_q[mem_addr];
      mem_read_data.valid = valid_q[mem_addr];   // flag array has the reset state
   end

endmodule

// File: alut_ctrl_pkg.sv
// control types for the address checker: command bus, FSM state and
// the destination port vector returned to the switch
`include "alut_defines.svh"

package alut_ctrl_pkg;

   typedef logic [1:0] alut_cmd_t;  // compare against `ALUT_CMD_CHECK

   // address checker FSM states
   typedef enum logic [2:0] {
      idle         = 3'b000,
      mac_addr_chk = 3'b001,  // destination is our own mac?
      read_dest    = 3'b010,  // table addressed by destination hash
      valid_chk    = 3'b011,  // latch destination entry
      age_chk      = 3'b100,  // wait on age checker
      addr_chk     = 3'b101,  // compare stored address
      read_src     = 3'b110,  // look at the entry about to be replaced
      write_src    = 3'b111   // learn source address and port
   } add_chk_state_t;

   // destination port vector with own_mac on bit 4
   typedef struct packed {
      logic                    own_mac;  // frame is for the switch itself
      logic [`ALUT_NPORTS-1:0] eth;      // one bit per ethernet port
   } dport_t;

endpackage

// File: alut_entry_pkg.sv
// data types for what is stored in the lookup table and for the
// fields of the frame that a check works on
// import in any module that carries table entries or frame fields
`include "alut_defines.svh"

package alut_entry_pkg;

   // one table entry, valid bit on top
   // written as {1, curr_time, s_port, s_addr} when a source is learned
   typedef struct packed {
      logic                    valid;      // entry holds a learned address
      logic [`ALUT_TIME_W-1:0] last_time;  // curr_time when written
      logic [`ALUT_PORT_W-1:0] port;       // port the address was seen on
      logic [`ALUT_ADDR_W-1:0] addr;       // learned mac address
   } alut_entry_t;

   // frame fields presented with a check command
   // must stay put while the check is running
   typedef struct packed {
      logic [`ALUT_ADDR_W-1:0] d_addr;     // destination, looked up
      logic [`ALUT_ADDR_W-1:0] s_addr;     // source, learned
      logic [`ALUT_PORT_W-1:0] s_port;     // port the frame came in on
   } frame_info_t;

endpackage

// File: alut_defines.svh
// sizing and command codes for the address lookup table
// include wherever a width or the check command is needed; the types
// built from these sizes live in the two alut packages
`ifndef ALUT_DEFINES_SVH
`define ALUT_DEFINES_SVH

// ----------------------------------------------------------------------
// table geometry
// ----------------------------------------------------------------------
`define ALUT_DEPTH 256        // entries in the lookup table
`define ALUT_HASH_W 8         // table index, xor of the address bytes

// ----------------------------------------------------------------------
// field widths
// ----------------------------------------------------------------------
`define ALUT_ADDR_W 48        // mac address
`define ALUT_TIME_W 32        // time stamp of last write
`define ALUT_PORT_W 2         // encoded ethernet port
`define ALUT_NPORTS 4         // ethernet ports on the switch

// ----------------------------------------------------------------------
// command bus codes
// ----------------------------------------------------------------------
`define ALUT_CMD_CHECK 2'b01  // check address, learn source

`endif
